/* list.f */
+incdir+.
execPkg.sv
issueQueue.sv
operandSelect.sv
alu.sv
execUnit.sv
resultBuffer.sv
execStage.sv
tbClock.sv
execStage_tb.sv

/* execStage_tb.sv */
// Directed testbench for the execute stage that runs as the simulation top against a reference model
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module execStage_tb;

    localparam int totalOps      = 52;   // Sum of the operations sent by all tests
    localparam int timeoutCycles = totalOps * 20 + 200;
    localparam int maxSigned     = (1 << (`EX_WIDTH - 1)) - 1;

    logic               clk;
    logic               rstN;
    logic               opValid;
    execPkg::exOp_t     op;
    logic               opCredit;
    execPkg::word_t     wbAluVal;
    execPkg::word_t     wbDataVal;
    logic               resValid;
    execPkg::exResult_t res;
    logic               resCredit;

    execPkg::exResult_t expQ[$];
    execPkg::exResult_t recvQ[$];
    execPkg::word_t     lastModel = '0;        // Model copy of the forwarding register
    logic [31:0]        lcgState = 32'd93;
    int                 upCredits = `EX_QUEUE_DEPTH;
    int                 creditsOwed = 0;       // Results received but not yet credited back
    logic               autoCredit = 1'b1;
    int                 creditPulses = 0;
    int                 cycles = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 testStartErrors = 0;
    int                 testsRun = 0;

    tbClock uClock (
        .clk  (clk),
        .rstN (rstN)
    );

    execStage dut (
        .clk         (clk),
        .rstN        (rstN),
        .opValid     (opValid),
        .op          (op),
        .opCredit    (opCredit),
        .memWbAluRes (wbAluVal),
        .memWbData   (wbDataVal),
        .resValid    (resValid),
        .res         (res),
        .resCredit   (resCredit)
    );

    function automatic execPkg::word_t nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    function automatic execPkg::word_t fwdValue(input execPkg::fwdSel_t sel,
                                                input execPkg::word_t  regVal);
        if (sel == execPkg::FWD_MEMWB) return wbAluVal;
        if (sel == execPkg::FWD_EXMEM) return lastModel;
        if (sel == execPkg::FWD_MEMDATA) return wbDataVal;
        return regVal;
    endfunction

    // Reference model of one operation built from the stage rules
    function automatic execPkg::exResult_t expectResult(input execPkg::exOp_t o);
        execPkg::word_t     rd1, rd2, inA, inB, a, b, out, rev, aluRes;
        execPkg::exResult_t r;
        logic [`EX_WIDTH:0] us;
        int                 sh, sa, sb, ss, ci;
        logic               zero, ltz, ofl, flag;
        rd1 = fwdValue(o.fwdA, o.readData1);
        rd2 = fwdValue(o.fwdB, o.readData2);
        if (o.aluOp == `AOP_LBI) inA = '0;
        else if (o.aluOp == `AOP_SLBI) inA = {rd1[7:0], 8'h00};
        else inA = rd1;
        if (o.aluOp[4:2] == `AOP_BRANCH_HI) inB = '0;
        else if (o.aluSrc) inB = o.immVal;
        else inB = rd2;
        a  = o.invA ? ~inA : inA;
        b  = o.invB ? ~inB : inB;
        sh = b[3:0];
        ci = o.cIn;
        us = a + b + o.cIn;
        sa = $signed(a);
        sb = $signed(b);
        ss = sa + sb + ci;                     // Exact signed sum without wrap
        case (o.aluCtl)
            3'd0:    out = (a << sh) | (a >> (`EX_WIDTH - sh));
            3'd1:    out = a << sh;
            3'd2:    out = (a >> sh) | (a << (`EX_WIDTH - sh));
            3'd3:    out = a >> sh;
            3'd4:    out = us[`EX_WIDTH-1:0];
            3'd5:    out = a & b;
            3'd6:    out = a | b;
            default: out = a ^ b;
        endcase
        zero = (out == '0);
        if (o.aluCtl != 3'd4) begin
            ltz = o.sign && out[`EX_WIDTH-1];
            ofl = 1'b0;
        end else if (o.sign) begin
            ltz = (ss < 0);
            ofl = (ss > maxSigned) || (ss < -maxSigned - 1);
        end else begin
            ltz = (o.invA || o.invB) && !us[`EX_WIDTH];   // Borrow
            ofl = us[`EX_WIDTH];
        end
        case (o.aluOp[1:0])
            2'b00:   flag = zero;
            2'b01:   flag = ltz;
            2'b10:   flag = zero || ltz;
            default: flag = ofl;
        endcase
        for (int i = 0; i < `EX_WIDTH; i++) rev[`EX_WIDTH-1-i] = rd1[i];
        if (o.aluOp == `AOP_JAL || o.aluOp == `AOP_JALR) aluRes = o.pc;
        else if (o.aluOp == `AOP_BTR) aluRes = rev;
        else if (o.aluOp[4:2] == `AOP_SET_HI) aluRes = execPkg::word_t'(flag);
        else aluRes = out;
        r.aluRes       = aluRes;
        r.memWriteData = rd2;
        r.readData1f   = rd1;
        r.zero         = zero;
        r.ltz          = ltz;
        r.err          = ofl;
        return r;
    endfunction

    // Ordinary ALU op reading registers only
    function automatic execPkg::exOp_t plainOp(input int ctl, input execPkg::word_t d1,
                                               input execPkg::word_t d2);
        execPkg::exOp_t o;
        o           = '0;
        o.aluOp     = 5'b10100;
        o.aluCtl    = execPkg::aluCtl_t'(ctl);
        o.fwdA      = execPkg::FWD_REG;
        o.fwdB      = execPkg::FWD_REG;
        o.readData1 = d1;
        o.readData2 = d2;
        return o;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic sendOp(input execPkg::exOp_t o);
        execPkg::exResult_t expRes;
        while (upCredits == 0) step();
        expRes = expectResult(o);
        expQ.push_back(expRes);
        lastModel = expRes.aluRes;
        opValid   = 1'b1;
        op        = o;
        upCredits--;
        step();
        opValid = 1'b0;
    endtask

    task automatic checkField(input string name, input int idx, input execPkg::word_t got,
                              input execPkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s (result %0d): got %h expected %h", name, idx, got, exp);
        end
    endtask

    task automatic waitResults(input int n);
        while (recvQ.size() < n) @(negedge clk);
    endtask

    // Waits for n results, compares them in order and prints the test line
    task automatic finishTest(input string name, input int n);
        execPkg::exResult_t got;
        execPkg::exResult_t exp;
        waitResults(n);
        for (int i = 0; i < n; i++) begin
            exp = expQ.pop_front();
            got = recvQ.pop_front();
            checkField("res.aluRes", i, got.aluRes, exp.aluRes);
            checkField("res.memWriteData", i, got.memWriteData, exp.memWriteData);
            checkField("res.readData1f", i, got.readData1f, exp.readData1f);
            checkField("res.zero", i, got.zero, exp.zero);
            checkField("res.ltz", i, got.ltz, exp.ltz);
            checkField("res.err", i, got.err, exp.err);
        end
        if (recvQ.size() != 0) begin
            errors++;
            $display("%0d results arrived that no operation asked for", recvQ.size());
            recvQ.delete();
        end
        step();
        testsRun++;
        $display("Test %s finished: %0d ops, %0d errors", name, n, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    task automatic resetTest();
        repeat (6) @(negedge clk) begin
            checks++;
            if (opCredit !== 1'b0 || resValid !== 1'b0) begin
                errors++;
                $display("Fail opCredit/resValid: got %h/%h expected 0/0", opCredit, resValid);
            end
        end
        step();
        finishTest("reset", 0);
    endtask

    task automatic aluFunctionTest();
        execPkg::exOp_t o;
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 2; k++) begin
                o      = plainOp(f, nextRand(), nextRand());
                o.sign = k[0];
                sendOp(o);
            end
        end
        for (int k = 0; k < 2; k++) begin
            o      = plainOp(4, nextRand(), nextRand());   // Subtract as A + ~B + 1
            o.invB = 1'b1;
            o.cIn  = 1'b1;
            o.sign = k[0];
            sendOp(o);
        end
        o      = plainOp(5, nextRand(), nextRand());
        o.invA = 1'b1;
        sendOp(o);
        o        = plainOp(4, nextRand(), nextRand());
        o.aluSrc = 1'b1;
        o.immVal = nextRand();
        sendOp(o);
        finishTest("ALU functions", 20);
    endtask

    task automatic forwardingTest();
        execPkg::exOp_t o;
        wbAluVal  = nextRand();
        wbDataVal = nextRand();
        for (int i = 0; i < 4; i++) begin
            o      = plainOp(6, nextRand(), nextRand());
            o.fwdA = execPkg::fwdSel_t'(i);
            o.fwdB = execPkg::fwdSel_t'((i + 1) % 4);
            sendOp(o);
        end
        // Back-to-back chain through the last-result register
        for (int i = 0; i < 3; i++) begin
            o      = plainOp(4, nextRand(), nextRand());
            o.fwdA = execPkg::FWD_EXMEM;
            if (i == 1) o.fwdB = execPkg::FWD_EXMEM;
            sendOp(o);
        end
        finishTest("forwarding", 7);
    endtask

    task automatic specialClassTest();
        execPkg::exOp_t o;
        execPkg::word_t d1;
        o        = plainOp(6, nextRand(), nextRand());
        o.aluOp  = `AOP_LBI;
        o.aluSrc = 1'b1;
        o.immVal = nextRand();
        sendOp(o);
        o        = plainOp(6, nextRand(), nextRand());
        o.aluOp  = `AOP_SLBI;
        o.aluSrc = 1'b1;
        o.immVal = nextRand() & 16'h00ff;
        sendOp(o);
        o       = plainOp(4, nextRand(), nextRand());
        o.aluOp = `AOP_BTR;
        sendOp(o);
        for (int k = 0; k < 4; k++) begin
            d1 = nextRand();
            if (k == 0) o = plainOp(4, d1, d1);             // Equal operands
            else if (k == 3) o = plainOp(4, 16'h8000, 16'h0001);
            else o = plainOp(4, d1, nextRand());
            o.aluOp = {`AOP_SET_HI, 2'(k)};
            o.invB  = 1'b1;
            o.cIn   = 1'b1;
            o.sign  = 1'b1;
            sendOp(o);
        end
        for (int k = 0; k < 2; k++) begin
            o       = plainOp(4, nextRand(), nextRand());
            o.aluOp = (k == 0) ? `AOP_JAL : `AOP_JALR;
            o.pc    = nextRand();
            sendOp(o);
        end
        for (int k = 0; k < 3; k++) begin
            d1      = (k == 0) ? 16'h0000 : (k == 1) ? 16'h8123 : 16'h0456;
            o       = plainOp(4, d1, nextRand());
            o.aluOp = {`AOP_BRANCH_HI, 2'b00};
            o.sign  = 1'b1;
            sendOp(o);
        end
        finishTest("special classes", 12);
    endtask

    task automatic overflowTest();
        execPkg::exOp_t o;
        o      = plainOp(4, 16'h7000, 16'h7000);
        o.sign = 1'b1;
        sendOp(o);
        o      = plainOp(4, 16'h9000, 16'h9000);
        o.sign = 1'b1;
        sendOp(o);
        o = plainOp(4, 16'h9000, 16'h9000);      // Unsigned add that should carry out
        sendOp(o);
        finishTest("overflow", 3);
    endtask

    task automatic backPressureTest();
        int startPulses;
        while (creditsOwed != 0) step();       // Earlier results fully credited back
        startPulses = creditPulses;
        autoCredit  = 1'b0;
        for (int i = 0; i < 10; i++) sendOp(plainOp(7, nextRand(), nextRand()));
        repeat (30) step();
        checks++;
        if (recvQ.size() != `EX_OUT_CREDITS) begin
            errors++;
            $display("Fail resValid count: got %h expected %h", recvQ.size(), `EX_OUT_CREDITS);
        end
        autoCredit = 1'b1;
        waitResults(10);
        checks++;
        if (creditPulses - startPulses != 10) begin
            errors++;
            $display("Fail opCredit pulses: got %h expected %h", creditPulses - startPulses, 10);
        end
        finishTest("back-pressure", 10);
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rstN) begin
            if (resValid === 1'b1) begin
                recvQ.push_back(res);
                creditsOwed++;
            end
            if (opCredit === 1'b1) begin
                upCredits++;
                creditPulses++;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (autoCredit && creditsOwed > 0) begin
            resCredit = 1'b1;
            creditsOwed--;
        end else begin
            resCredit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeoutCycles) begin
            $display("Timeout after %0d cycles, results stopped arriving", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        opValid   = 1'b0;
        op        = '0;
        wbAluVal  = '0;
        wbDataVal = '0;
        resCredit = 1'b0;
        resetTest();
        aluFunctionTest();
        forwardingTest();
        specialClassTest();
        overflowTest();
        backPressureTest();
        $display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tbClock.sv */
// Testbench clock and reset source, 8 ns period with rstN held low for the first two rising edges
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;    // Released on the same offset as other inputs
    end

endmodule

`default_nettype wire

/* execStage.sv */
// Execute stage top level, joins the issue queue, the execution unit and the result buffer
`timescale 1ns/100ps
`default_nettype none

module execStage (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               opValid,
    input  wire execPkg::exOp_t     op,
    output logic                    opCredit,
    input  wire execPkg::word_t     memWbAluRes,
    input  wire execPkg::word_t     memWbData,
    output logic                    resValid,
    output execPkg::exResult_t      res,
    input  wire logic               resCredit
);

    logic               headValid;
    execPkg::exOp_t     headOp;
    logic               take;
    logic               space;
    logic               resultValid;
    execPkg::exResult_t result;

    issueQueue uIssueQueue (
        .clk       (clk),
        .rstN      (rstN),
        .opValid   (opValid),
        .op        (op),
        .opCredit  (opCredit),
        .take      (take),
        .headValid (headValid),
        .headOp    (headOp)
    );

    execUnit uExecUnit (
        .clk         (clk),
        .rstN        (rstN),
        .headValid   (headValid),
        .headOp      (headOp),
        .space       (space),       // Back-pressure from the output side
        .memWbAluRes (memWbAluRes),
        .memWbData   (memWbData),
        .take        (take),
        .resultValid (resultValid),
        .result      (result)
    );

    resultBuffer uResultBuffer (
        .clk         (clk),
        .rstN        (rstN),
        .resultValid (resultValid),
        .result      (result),
        .space       (space),
        .resValid    (resValid),
        .res         (res),
        .resCredit   (resCredit)
    );

endmodule

`default_nettype wire

/* resultBuffer.sv */
// Output side of the execute stage, buffers results and sends them on against downstream credits
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module resultBuffer (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               resultValid,
    input  wire execPkg::exResult_t result,
    output logic                    space,
    output logic                    resValid,
    output execPkg::exResult_t      res,
    input  wire logic               resCredit
);

    localparam int outDepth    = `EX_OUT_DEPTH;
    localparam int outCredits  = `EX_OUT_CREDITS;
    localparam int ptrWidth    = $clog2(outDepth);
    localparam int cntWidth    = $clog2(outDepth + 1);
    localparam int creditWidth = $clog2(outCredits + 1);

    execPkg::exResult_t     entries [outDepth];
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [cntWidth-1:0]    count;
    logic [creditWidth-1:0] credits;
    logic                   push;
    logic                   send;

    assign space = (count != cntWidth'(outDepth));
    assign push  = resultValid & space;
    assign send  = (count != '0) && (credits != '0);   // Head leaves once a credit is held

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= result;
        end
    end

    // Registered output word
    always_ff @(posedge clk) begin
        if (send) begin
            res <= entries[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            credits  <= creditWidth'(outCredits);
            resValid <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(outDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (send) begin
                rdPtr <= (rdPtr == ptrWidth'(outDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // A returned credit and a send in one cycle cancel out
            case ({resCredit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            resValid <= send;   // One cycle per result
        end
    end

endmodule

`default_nettype wire

/* execUnit.sv */
// Processing part of the execute stage, runs the head op and keeps the last result for forwarding
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module execUnit (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire logic           headValid,
    input  wire execPkg::exOp_t headOp,
    input  wire logic           space,
    input  wire execPkg::word_t memWbAluRes,
    input  wire execPkg::word_t memWbData,
    output logic                take,
    output logic                resultValid,
    output execPkg::exResult_t  result
);

    localparam int width = `EX_WIDTH;

    execPkg::word_t lastRes;
    execPkg::word_t readData1f;
    execPkg::word_t readData2f;
    execPkg::word_t aluInA;
    execPkg::word_t aluInB;
    execPkg::word_t aluOut;
    execPkg::word_t btrVal;
    execPkg::word_t aluRes;
    logic           zero;
    logic           ltz;
    logic           ofl;
    logic           setFlag;
    logic           isSet;
    logic           isBtr;
    logic           isLink;

    // Execute only when the result has somewhere to go
    assign take        = headValid & space;
    assign resultValid = take;

    operandSelect uOperandSelect (
        .op          (headOp),
        .lastRes     (lastRes),
        .memWbAluRes (memWbAluRes),
        .memWbData   (memWbData),
        .readData1f  (readData1f),
        .readData2f  (readData2f),
        .aluInA      (aluInA),
        .aluInB      (aluInB)
    );

    alu uAlu (
        .inA    (aluInA),
        .inB    (aluInB),
        .aluCtl (headOp.aluCtl),
        .invA   (headOp.invA),
        .invB   (headOp.invB),
        .cIn    (headOp.cIn),
        .sign   (headOp.sign),
        .out    (aluOut),
        .zero   (zero),
        .ltz    (ltz),
        .ofl    (ofl)
    );

    assign isSet  = (headOp.aluOp[4:2] == `AOP_SET_HI);
    assign isBtr  = (headOp.aluOp == `AOP_BTR);
    assign isLink = (headOp.aluOp == `AOP_JAL) || (headOp.aluOp == `AOP_JALR);

    // seq, slt, sle, sco
    always_comb begin
        case (headOp.aluOp[1:0])
            2'b00:   setFlag = zero;
            2'b01:   setFlag = ltz;
            2'b10:   setFlag = zero | ltz;
            default: setFlag = ofl;
        endcase
    end

    always_comb begin
        for (int i = 0; i < width; i++) begin
            btrVal[i] = readData1f[width-1-i];   // Bit reverse
        end
    end

    always_comb begin
        if (isLink) begin
            aluRes = headOp.pc;
        end else if (isBtr) begin
            aluRes = btrVal;
        end else if (isSet) begin
            aluRes = {{(width-1){1'b0}}, setFlag};
        end else begin
            aluRes = aluOut;
        end
    end

    always_comb begin
        result.aluRes       = aluRes;
        result.memWriteData = readData2f;   // Store data path
        result.readData1f   = readData1f;
        result.zero         = zero;
        result.ltz          = ltz;
        result.err          = ofl;
    end

    // Source for FWD_EXMEM on the next op
    always_ff @(posedge clk) begin
        if (!rstN) begin
            lastRes <= '0;
        end else if (take) begin
            lastRes <= aluRes;
        end
    end

endmodule

`default_nettype wire

/* alu.sv */
// 16-bit shift, rotate, add and logic unit with zero, sign and overflow flags
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module alu (
    input  wire execPkg::word_t   inA,
    input  wire execPkg::word_t   inB,
    input  wire execPkg::aluCtl_t aluCtl,
    input  wire logic             invA,
    input  wire logic             invB,
    input  wire logic             cIn,
    input  wire logic             sign,
    output execPkg::word_t        out,
    output logic                  zero,
    output logic                  ltz,
    output logic                  ofl
);

    localparam int width   = `EX_WIDTH;
    localparam int shWidth = $clog2(width);

    execPkg::word_t     a;
    execPkg::word_t     b;
    logic [shWidth-1:0] shAmt;
    logic [width:0]     sum;
    logic [2*width-1:0] rolTmp;
    logic [2*width-1:0] rorTmp;
    logic               isAdd;
    logic               carry;
    logic               sOfl;

    assign a     = invA ? ~inA : inA;
    assign b     = invB ? ~inB : inB;
    assign shAmt = b[shWidth-1:0];     // Low bits of input 2

    // Adder with carry in and one extra bit for carry out
    assign sum   = {1'b0, a} + {1'b0, b} + {{width{1'b0}}, cIn};
    assign carry = sum[width];
    assign sOfl  = (a[width-1] == b[width-1]) && (sum[width-1] != a[width-1]);

    // Rotates through a doubled word
    assign rolTmp = {a, a} << shAmt;
    assign rorTmp = {a, a} >> shAmt;

    assign isAdd = (aluCtl == 3'd4);

    always_comb begin
        case (aluCtl)
            3'd0:    out = rolTmp[2*width-1:width];   // Rotate left
            3'd1:    out = a << shAmt;
            3'd2:    out = rorTmp[width-1:0];         // Rotate right
            3'd3:    out = a >> shAmt;                // Logical
            3'd4:    out = sum[width-1:0];
            3'd5:    out = a & b;
            3'd6:    out = a | b;
            default: out = a ^ b;
        endcase
    end

    assign zero = (out == '0);

    // Signed add gives the true sign even on overflow
    // Unsigned subtract flags a borrow as no carry out
    always_comb begin
        if (isAdd) begin
            ltz = sign ? (sum[width-1] ^ sOfl) : ((invA | invB) & ~carry);
            ofl = sign ? sOfl : carry;
        end else begin
            ltz = sign & out[width-1];
            ofl = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* operandSelect.sv */
// Operand forwarding and ALU input selection for the execute stage, purely combinational
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module operandSelect (
    input  wire execPkg::exOp_t op,
    input  wire execPkg::word_t lastRes,
    input  wire execPkg::word_t memWbAluRes,
    input  wire execPkg::word_t memWbData,
    output execPkg::word_t      readData1f,
    output execPkg::word_t      readData2f,
    output execPkg::word_t      aluInA,
    output execPkg::word_t      aluInB
);

    execPkg::word_t srcB;
    logic           isSlbi;
    logic           isLbi;
    logic           isBranch;

    // Same four-way source choice for both operands
    function automatic execPkg::word_t fwdMux(input execPkg::fwdSel_t sel,
                                              input execPkg::word_t  regVal,
                                              input execPkg::word_t  exMem,
                                              input execPkg::word_t  wbAlu,
                                              input execPkg::word_t  wbMem);
        case (sel)
            execPkg::FWD_MEMWB:   return wbAlu;
            execPkg::FWD_EXMEM:   return exMem;
            execPkg::FWD_MEMDATA: return wbMem;
            default:              return regVal;
        endcase
    endfunction

    assign readData1f = fwdMux(op.fwdA, op.readData1, lastRes, memWbAluRes, memWbData);
    assign readData2f = fwdMux(op.fwdB, op.readData2, lastRes, memWbAluRes, memWbData);

    assign isSlbi   = (op.aluOp == `AOP_SLBI);
    assign isLbi    = (op.aluOp == `AOP_LBI);
    assign isBranch = (op.aluOp[4:2] == `AOP_BRANCH_HI);

    // Input A, lbi passes the immediate through an OR against zero
    always_comb begin
        if (isLbi) begin
            aluInA = '0;
        end else if (isSlbi) begin
            aluInA = readData1f << 8;    // Old low byte moves up
        end else begin
            aluInA = readData1f;
        end
    end

    // Branches test readData1f alone against zero
    assign srcB   = op.aluSrc ? op.immVal : readData2f;
    assign aluInB = isBranch ? '0 : srcB;

endmodule

`default_nettype wire

/* issueQueue.sv */
// Input side of the execute stage, queues decoded operations and returns one credit per pop
`timescale 1ns/100ps
`default_nettype none

`include "exec_settings.svh"

module issueQueue (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire logic           opValid,
    input  wire execPkg::exOp_t op,
    output logic                opCredit,
    input  wire logic           take,
    output logic                headValid,
    output execPkg::exOp_t      headOp
);

    localparam int queueDepth = `EX_QUEUE_DEPTH;
    localparam int ptrWidth   = $clog2(queueDepth);
    localparam int cntWidth   = $clog2(queueDepth + 1);

    execPkg::exOp_t      entries [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                push;
    logic                pop;

    // Upstream only sends against a credit, so a free entry always exists
    assign push = opValid;
    assign pop  = take & headValid;

    // Operation storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            opCredit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle, or push and pop together
            endcase
            opCredit <= pop;               // One pulse per released entry
        end
    end

    // Head is visible the cycle after it is written
    assign headValid = (count != '0);
    assign headOp    = entries[rdPtr];

endmodule

`default_nettype wire

/* execPkg.sv */
// Shared execute stage types, referenced by scoped name from each RTL file that needs them
`default_nettype none

`include "exec_settings.svh"

package execPkg;

    typedef logic [`EX_WIDTH-1:0] word_t;   // One data word
    typedef logic [4:0]           aluOp_t;  // Operation class from decode
    typedef logic [2:0]           aluCtl_t; // ALU function select

    // Where a forwarded operand comes from
    typedef enum logic [1:0] {
        FWD_REG     = 2'd0,   // Register file value
        FWD_MEMWB   = 2'd1,   // Write-back ALU result
        FWD_EXMEM   = 2'd2,   // Previous result of this stage
        FWD_MEMDATA = 2'd3    // Write-back memory data
    } fwdSel_t;

    // Decoded operation entering the stage
    typedef struct packed {
        aluOp_t  aluOp;
        aluCtl_t aluCtl;
        logic    aluSrc;      // Immediate as ALU input B
        logic    invA;
        logic    invB;
        logic    cIn;
        logic    sign;
        fwdSel_t fwdA;
        fwdSel_t fwdB;
        word_t   readData1;
        word_t   readData2;
        word_t   immVal;
        word_t   pc;          // Link address, already incremented upstream
    } exOp_t;

    // Result handed on to the memory stage
    typedef struct packed {
        word_t aluRes;
        word_t memWriteData;
        word_t readData1f;    // Forwarded first operand
        logic  zero;
        logic  ltz;
        logic  err;           // ALU overflow or carry
    } exResult_t;

endpackage

`default_nettype wire

/* exec_settings.svh */
// Execute stage widths, depths, credit counts and opcode classes, included by RTL and testbench
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath
`define EX_WIDTH         16

// Buffering and flow control
`define EX_QUEUE_DEPTH   4       // Also the upstream credit count after reset
`define EX_OUT_DEPTH     4
`define EX_OUT_CREDITS   2       // Downstream credits held after reset

// Operation classes with special result handling
`define AOP_SLBI         5'b10010
`define AOP_LBI          5'b11000
`define AOP_BTR          5'b11001
`define AOP_JAL          5'b00110
`define AOP_JALR         5'b00111

// Upper opcode bits shared by a whole group
`define AOP_BRANCH_HI    3'b011
`define AOP_SET_HI       3'b111

`endif
